//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_dp_core
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- source/barrel_shift.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shift import core_pkg::*; (
    input  wire logic [ROT_W+IMM8_W-1:0]    operand2,
    input  wire logic                       imm_flag,
    input  wire logic [DATA_W-1:0]          rm_value,
    output logic [DATA_W-1:0]               shifted
);

    instr_u                 word;
    logic [ROT_W-1:0]       rot;
    logic [IMM8_W-1:0]      imm8;
    logic [SHAMT_W-1:0]     shamt;
    logic [1:0]             sh_type;
    logic [DATA_W-1:0]      imm_value;

    function automatic logic [DATA_W-1:0] ror32(
        input logic [DATA_W-1:0]    value,
        input logic [SHAMT_W-1:0]   amount
    );
        logic [2*DATA_W-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[DATA_W-1:0];
    endfunction

    // operand2 placed in its slot of a dp word
    assign word = DATA_W'(operand2);

    assign {rot, imm8}      = word.dp.operand2;
    assign {shamt, sh_type} = word.dp.operand2[ROT_W+IMM8_W-1:ROT_W+IMM8_W-SHAMT_W-2];

    // imm8 rotated right by twice rot
    assign imm_value = ror32({{(DATA_W-IMM8_W){1'b0}}, imm8}, {rot, 1'b0});

    always_comb begin
        shifted = rm_value;
        if (imm_flag) begin
            shifted = imm_value;
        end else begin
            // amount zero falls out unchanged for every type
            case (sh_type)
                SH_LSL: shifted = rm_value << shamt;
                SH_LSR: shifted = rm_value >> shamt;
                SH_ASR: shifted = $signed(rm_value) >>> shamt;
                SH_ROR: shifted = ror32(rm_value, shamt);
                default: shifted = rm_value;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = 4;
    localparam int ADDR_W    = 8;
    localparam int SHAMT_W   = 5;
    localparam int IMM8_W    = 8;
    localparam int ROT_W     = 4;

    // register map
    localparam logic [ADDR_W-1:0] INSTR_OFFSET = 8'h00;
    localparam logic [ADDR_W-1:0] READ_LIMIT   = 8'h3C;

    // data-processing opcodes, bits 24:21
    localparam logic [3:0] OP_AND = 4'b0000;
    localparam logic [3:0] OP_EOR = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_ADD = 4'b0100;
    localparam logic [3:0] OP_ORR = 4'b1100;
    localparam logic [3:0] OP_MOV = 4'b1101;

    localparam logic [1:0] SH_LSL = 2'b00;
    localparam logic [1:0] SH_LSR = 2'b01;
    localparam logic [1:0] SH_ASR = 2'b10;
    localparam logic [1:0] SH_ROR = 2'b11;

    localparam logic [3:0] MUL_MARK = 4'b1001;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        ALU_AND,
        ALU_EOR,
        ALU_SUB,
        ALU_ADD,
        ALU_ORR,
        ALU_MOV,
        ALU_MUL,
        ALU_MLA
    } alu_op_t;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [3:0]                 cond;
            logic [1:0]                 cls;
            logic                       imm_flag;
            logic [3:0]                 opcode;
            logic                       s;
            logic [REG_IDX_W-1:0]       rn;
            logic [REG_IDX_W-1:0]       rd;
            logic [ROT_W+IMM8_W-1:0]    operand2;
        } dp;
        struct packed {
            logic [3:0]                 cond;
            logic [5:0]                 zeros;
            logic                       acc;
            logic                       s;
            logic [REG_IDX_W-1:0]       rd;
            logic [REG_IDX_W-1:0]       rn;
            logic [REG_IDX_W-1:0]       rs;
            logic [3:0]                 marker;
            logic [REG_IDX_W-1:0]       rm;
        } mul;
    } instr_u;

endpackage

`default_nettype wire

//--- source/dp_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module dp_core_top import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   awvalid,
    input  wire logic [ADDR_W-1:0]      awaddr,
    output logic                        awready,
    input  wire logic                   wvalid,
    input  wire logic [DATA_W-1:0]      wdata,
    input  wire logic [DATA_W/8-1:0]    wstrb,
    output logic                        wready,
    output logic                        bvalid,
    output logic [1:0]                  bresp,
    input  wire logic                   bready,
    input  wire logic                   arvalid,
    input  wire logic [ADDR_W-1:0]      araddr,
    output logic                        arready,
    output logic                        rvalid,
    output logic [DATA_W-1:0]           rdata,
    output logic [1:0]                  rresp,
    input  wire logic                   rready
);

    logic                   issue_valid;
    instr_u                 issue_word;
    logic [REG_IDX_W-1:0]   dec_ra1;
    logic [REG_IDX_W-1:0]   dec_ra2;
    logic [REG_IDX_W-1:0]   dec_ra3;
    logic [REG_IDX_W-1:0]   rb_ra3;
    logic [REG_IDX_W-1:0]   rf_ra3;
    logic [DATA_W-1:0]      rd1;
    logic [DATA_W-1:0]      rd2;
    logic [DATA_W-1:0]      rd3;
    logic                   ex_valid;
    alu_op_t                ex_op;
    logic [DATA_W-1:0]      ex_a;
    logic [DATA_W-1:0]      ex_b;
    logic [DATA_W-1:0]      ex_c;
    logic [REG_IDX_W-1:0]   ex_rd;
    logic                   wb_valid;
    logic [REG_IDX_W-1:0]   wb_rd;
    logic [DATA_W-1:0]      wb_data;
    logic                   busy;

    assign busy = issue_valid || ex_valid || wb_valid;

    // third port is shared: decode while busy, read-back when idle
    assign rf_ra3 = busy ? dec_ra3 : rb_ra3;

    instr_intake u_intake (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .issue_valid(issue_valid), .issue_word(issue_word)
    );

    operand_decode u_decode (
        .clk(clk), .reset(reset),
        .issue_valid(issue_valid), .issue_word(issue_word),
        .ra1(dec_ra1), .ra2(dec_ra2), .ra3(dec_ra3),
        .rd1(rd1), .rd2(rd2), .rd3(rd3),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b),
        .ex_c(ex_c), .ex_rd(ex_rd)
    );

    register_file u_regs (
        .clk(clk), .reset(reset),
        .ra1(dec_ra1), .ra2(dec_ra2), .ra3(rf_ra3),
        .rd1(rd1), .rd2(rd2), .rd3(rd3),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b),
        .ex_c(ex_c), .ex_rd(ex_rd),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    reg_readback u_readback (
        .clk(clk), .reset(reset), .busy(busy),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .ra3(rb_ra3), .rd3(rd3)
    );

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   ex_valid,
    input  wire alu_op_t                ex_op,
    input  wire logic [DATA_W-1:0]      ex_a,
    input  wire logic [DATA_W-1:0]      ex_b,
    input  wire logic [DATA_W-1:0]      ex_c,
    input  wire logic [REG_IDX_W-1:0]   ex_rd,
    output logic                        wb_valid,
    output logic [REG_IDX_W-1:0]        wb_rd,
    output logic [DATA_W-1:0]           wb_data
);

    logic [DATA_W-1:0] product;
    logic [DATA_W-1:0] result;

    // low half only
    assign product = ex_a * ex_b;

    always_comb begin
        result = ex_b;
        case (ex_op)
            ALU_AND: result = ex_a & ex_b;
            ALU_EOR: result = ex_a ^ ex_b;
            ALU_SUB: result = ex_a - ex_b;
            ALU_ADD: result = ex_a + ex_b;
            ALU_ORR: result = ex_a | ex_b;
            ALU_MOV: result = ex_b;
            ALU_MUL: result = product;
            ALU_MLA: result = product + ex_c;
            default: result = ex_b;
        endcase
    end

    ////////////////////////////////////////
    // write-back register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- source/instr_intake.sv
`timescale 1ns/1ps
`default_nettype none

module instr_intake import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   awvalid,
    input  wire logic [ADDR_W-1:0]      awaddr,
    output logic                        awready,
    input  wire logic                   wvalid,
    input  wire logic [DATA_W-1:0]      wdata,
    input  wire logic [DATA_W/8-1:0]    wstrb,
    output logic                        wready,
    output logic                        bvalid,
    output logic [1:0]                  bresp,
    input  wire logic                   bready,
    output logic                        issue_valid,
    output instr_u                      issue_word
);

    logic accept;
    logic legal;
    logic bvalid_next;
    logic ready;

    // address and data must arrive together
    assign accept = awvalid && wvalid && ready;
    assign legal  = (awaddr == INSTR_OFFSET) && (&wstrb);

    assign bvalid_next = accept ? 1'b1 : ((bvalid && bready) ? 1'b0 : bvalid);

    assign awready = ready;
    assign wready  = ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bvalid      <= 1'b0;
            ready       <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            bvalid      <= bvalid_next;
            // open again only once the response is gone
            ready       <= !bvalid_next;
            issue_valid <= accept && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bresp      <= legal ? RESP_OKAY : RESP_SLVERR;
            issue_word <= wdata;
        end
    end

    ////////////////////////////////////////
    // checks

    a_bresp_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

//--- source/operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module operand_decode import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   issue_valid,
    input  wire instr_u                 issue_word,
    output logic [REG_IDX_W-1:0]        ra1,
    output logic [REG_IDX_W-1:0]        ra2,
    output logic [REG_IDX_W-1:0]        ra3,
    input  wire logic [DATA_W-1:0]      rd1,
    input  wire logic [DATA_W-1:0]      rd2,
    input  wire logic [DATA_W-1:0]      rd3,
    input  wire logic                   wb_valid,
    input  wire logic [REG_IDX_W-1:0]   wb_rd,
    input  wire logic [DATA_W-1:0]      wb_data,
    output logic                        ex_valid,
    output alu_op_t                     ex_op,
    output logic [DATA_W-1:0]           ex_a,
    output logic [DATA_W-1:0]           ex_b,
    output logic [DATA_W-1:0]           ex_c,
    output logic [REG_IDX_W-1:0]        ex_rd
);

    logic               is_mul;
    logic               is_dp;
    logic               dp_known;
    alu_op_t            dp_op;
    logic [DATA_W-1:0]  a_value;
    logic [DATA_W-1:0]  b_value;
    logic [DATA_W-1:0]  c_value;
    logic [DATA_W-1:0]  shifted;

    function automatic logic [DATA_W-1:0] bypass(
        input logic [REG_IDX_W-1:0] idx,
        input logic [DATA_W-1:0]    rf_value,
        input logic                 fwd_valid,
        input logic [REG_IDX_W-1:0] fwd_rd,
        input logic [DATA_W-1:0]    fwd_data
    );
        return (fwd_valid && fwd_rd == idx) ? fwd_data : rf_value;
    endfunction

    ////////////////////////////////////////
    // decode

    assign is_mul = (issue_word.mul.zeros == '0) && (issue_word.mul.marker == MUL_MARK);

    always_comb begin
        dp_known = 1'b1;
        dp_op    = ALU_MOV;
        case (issue_word.dp.opcode)
            OP_AND: dp_op = ALU_AND;
            OP_EOR: dp_op = ALU_EOR;
            OP_SUB: dp_op = ALU_SUB;
            OP_ADD: dp_op = ALU_ADD;
            OP_ORR: dp_op = ALU_ORR;
            OP_MOV: dp_op = ALU_MOV;
            default: dp_known = 1'b0;
        endcase
    end

    // register form with bit 4 set would be an Rs shift
    assign is_dp = !is_mul && (issue_word.dp.cls == 2'b00) && dp_known &&
                   (issue_word.dp.imm_flag || !issue_word.dp.operand2[4]);

    // port 1 Rn or Rm, port 2 Rm or Rs, port 3 accumulator
    assign ra1 = is_mul ? issue_word.mul.rm : issue_word.dp.rn;
    assign ra2 = is_mul ? issue_word.mul.rs : issue_word.dp.operand2[REG_IDX_W-1:0];
    assign ra3 = issue_word.mul.rn;

    assign a_value = bypass(ra1, rd1, wb_valid, wb_rd, wb_data);
    assign b_value = bypass(ra2, rd2, wb_valid, wb_rd, wb_data);
    assign c_value = bypass(ra3, rd3, wb_valid, wb_rd, wb_data);

    barrel_shift u_shift (
        .operand2 (issue_word.dp.operand2),
        .imm_flag (issue_word.dp.imm_flag),
        .rm_value (b_value),
        .shifted  (shifted)
    );

    ////////////////////////////////////////
    // stage register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid && (is_mul || is_dp);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_op <= is_mul ? (issue_word.mul.acc ? ALU_MLA : ALU_MUL) : dp_op;
            ex_a  <= a_value;
            ex_b  <= is_mul ? b_value : shifted;
            ex_c  <= c_value;
            ex_rd <= is_mul ? issue_word.mul.rd : issue_word.dp.rd;
        end
    end

endmodule

`default_nettype wire

//--- source/reg_readback.sv
`timescale 1ns/1ps
`default_nettype none

module reg_readback import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   busy,
    input  wire logic                   arvalid,
    input  wire logic [ADDR_W-1:0]      araddr,
    output logic                        arready,
    output logic                        rvalid,
    output logic [DATA_W-1:0]           rdata,
    output logic [1:0]                  rresp,
    input  wire logic                   rready,
    output logic [REG_IDX_W-1:0]        ra3,
    input  wire logic [DATA_W-1:0]      rd3
);

    logic accept;
    logic in_range;
    logic rvalid_next;
    logic ar_open;

    // only take a read once the pipeline has drained
    assign arready = ar_open && !busy;
    assign accept  = arvalid && arready;

    assign in_range = (araddr <= READ_LIMIT);
    assign ra3      = araddr[REG_IDX_W+1:2];

    assign rvalid_next = accept ? 1'b1 : ((rvalid && rready) ? 1'b0 : rvalid);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rvalid  <= 1'b0;
            ar_open <= 1'b0;
        end else begin
            rvalid  <= rvalid_next;
            ar_open <= !rvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= in_range ? rd3 : '0;
            rresp <= in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [REG_IDX_W-1:0]   ra1,
    input  wire logic [REG_IDX_W-1:0]   ra2,
    input  wire logic [REG_IDX_W-1:0]   ra3,
    output logic [DATA_W-1:0]           rd1,
    output logic [DATA_W-1:0]           rd2,
    output logic [DATA_W-1:0]           rd3,
    input  wire logic                   we,
    input  wire logic [REG_IDX_W-1:0]   wa,
    input  wire logic [DATA_W-1:0]      wd
);

    logic [DATA_W-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // reads see the old value during a write
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign rd3 = regs[ra3];

    a_wd_known: assert property (@(posedge clk) disable iff (reset)
        we |-> !$isunknown(wd));

endmodule

`default_nettype wire

//--- verification/tb_dp_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dp_core import core_pkg::*; ();

    // whole run is near 1000 cycles
    localparam int MAX_CYCLES = 4000;

    logic               clk = 1'b0;
    logic               reset;
    logic               awvalid;
    logic [ADDR_W-1:0]  awaddr;
    logic               awready;
    logic               wvalid;
    logic [DATA_W-1:0]  wdata;
    logic [3:0]         wstrb;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               bready;
    logic               arvalid;
    logic [ADDR_W-1:0]  araddr;
    logic               arready;
    logic               rvalid;
    logic [DATA_W-1:0]  rdata;
    logic [1:0]         rresp;
    logic               rready;

    logic [DATA_W-1:0]  model [REG_COUNT];
    logic [1:0]         exp_bresp = RESP_OKAY;
    logic [DATA_W-1:0]  exp_rdata = '0;
    logic [1:0]         exp_rresp = RESP_OKAY;
    logic [31:0]        rng = 32'h657e;
    int                 cycles = 0;

    dp_core_top UUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_fail($sformatf("timeout, run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////
    // reference model

    // one bit position per step
    function automatic logic [31:0] shift_model(input logic [31:0] v, input logic [1:0] kind,
                                                input int n);
        logic [31:0] r;
        r = v;
        for (int i = 0; i < n; i++) begin
            case (kind)
                SH_LSL: r = {r[30:0], 1'b0};
                SH_LSR: r = {1'b0, r[31:1]};
                SH_ASR: r = {r[31], r[31:1]};
                default: r = {r[0], r[31:1]};
            endcase
        end
        return r;
    endfunction

    function automatic logic [3:0] pick_op(input logic [2:0] sel);
        case (sel)
            3'd0: return OP_AND;
            3'd1: return OP_EOR;
            3'd2: return OP_SUB;
            3'd3: return OP_ADD;
            default: return OP_ORR;
        endcase
    endfunction

    function automatic logic [31:0] dp_imm_word(input logic [3:0] op, input logic [3:0] rn,
                                                input logic [3:0] rd, input logic [3:0] rot,
                                                input logic [7:0] imm8);
        return {4'hE, 2'b00, 1'b1, op, 1'b0, rn, rd, rot, imm8};
    endfunction

    function automatic logic [31:0] dp_reg_word(input logic [3:0] op, input logic [3:0] rn,
                                                input logic [3:0] rd, input logic [4:0] amt,
                                                input logic [1:0] kind, input logic [3:0] rm);
        return {4'hE, 2'b00, 1'b0, op, 1'b0, rn, rd, amt, kind, 1'b0, rm};
    endfunction

    function automatic logic [31:0] mul_word(input logic acc, input logic [3:0] rd,
                                             input logic [3:0] rn, input logic [3:0] rs,
                                             input logic [3:0] rm);
        return {4'hE, 6'b000000, acc, 1'b0, rd, rn, rs, MUL_MARK, rm};
    endfunction

    ////////////////////////////////////////
    // bus tasks, entered and left on a falling edge

    task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] resp, input int hold);
        awvalid = 1'b1;
        wvalid = 1'b1;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        exp_bresp = resp;
        bready = (hold == 0);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (hold) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic read_back(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        arvalid = 1'b1;
        araddr = addr;
        exp_rdata = data;
        exp_rresp = resp;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic check_reg(input logic [3:0] idx);
        read_back({2'b00, idx, 2'b00}, model[idx], RESP_OKAY);
    endtask

    // model follows the word, then the word goes out
    task automatic send_instr(input logic [31:0] w, input int hold);
        logic [31:0] a;
        logic [31:0] op2;
        logic [31:0] res;
        if (w[27:22] == 6'b000000 && w[7:4] == MUL_MARK) begin
            res = model[w[3:0]] * model[w[11:8]];
            if (w[21]) begin
                res = res + model[w[15:12]];
            end
            model[w[19:16]] = res;
        end else if (w[27:26] == 2'b00 && (w[25] || !w[4])) begin
            a = model[w[19:16]];
            if (w[25]) begin
                op2 = shift_model({24'h0, w[7:0]}, SH_ROR, 2 * int'(w[11:8]));
            end else begin
                op2 = shift_model(model[w[3:0]], w[6:5], int'(w[11:7]));
            end
            case (w[24:21])
                OP_AND: model[w[15:12]] = a & op2;
                OP_EOR: model[w[15:12]] = a ^ op2;
                OP_SUB: model[w[15:12]] = a - op2;
                OP_ADD: model[w[15:12]] = a + op2;
                OP_ORR: model[w[15:12]] = a | op2;
                OP_MOV: model[w[15:12]] = op2;
                default: ;
            endcase
        end
        write_word(INSTR_OFFSET, w, 4'hF, RESP_OKAY, hold);
    endtask

    task automatic load_reg(input logic [3:0] rd);
        rng = xorshift(rng);
        send_instr(dp_imm_word(OP_MOV, 4'h0, rd, rng[3:0], rng[15:8]), 0);
        send_instr(dp_imm_word(OP_ORR, rd, rd, rng[19:16], rng[31:24]), 0);
    endtask

    ////////////////////////////////////////
    // checks

    a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |->
        !bvalid && !rvalid && !awready && !arready)
        else report_fail($sformatf("ERR %0t: handshake outputs active after reset", $time));

    a_bresp: assert property (@(posedge clk) disable iff (reset)
        bvalid && bready |-> bresp == exp_bresp)
        else report_fail($sformatf("ERR %0t: bresp %0b, expected %0b", $time, bresp, exp_bresp));

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> rdata == exp_rdata && rresp == exp_rresp)
        else report_fail($sformatf("ERR %0t: rdata %h rresp %0b, expected %h %0b",
                                   $time, rdata, rresp, exp_rdata, exp_rresp));

    a_bhold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else report_fail($sformatf("ERR %0t: write response dropped or changed", $time));

    a_no_accept: assert property (@(posedge clk) disable iff (reset)
        bvalid |-> !awready && !wready)
        else report_fail($sformatf("ERR %0t: write ready while response pending", $time));

    initial begin
        logic [3:0] src;
        logic [3:0] dst;
        logic [3:0] dst2;
        logic [3:0] prev;
        logic [3:0] rs_i;
        logic [3:0] rn_i;
        logic [4:0] amt;
        for (int n = 0; n < REG_COUNT; n++) begin
            model[n] = '0;
        end
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // every register clear
        for (int n = 0; n < REG_COUNT; n++) begin
            check_reg(4'(n));
        end

        // rotated immediates
        for (int i = 0; i < 10; i++) begin
            rng = xorshift(rng);
            send_instr(dp_imm_word(OP_MOV, rng[7:4], rng[3:0], rng[11:8], rng[19:12]), 0);
            check_reg(rng[3:0]);
        end

        // dependent chains, each on the last destination
        for (int n = 0; n < REG_COUNT; n++) begin
            load_reg(4'(n));
        end
        for (int c = 0; c < 5; c++) begin
            rng = xorshift(rng);
            prev = rng[3:0];
            for (int i = 0; i < 6; i++) begin
                rng = xorshift(rng);
                dst = rng[3:0];
                if (rng[31]) begin
                    send_instr(dp_imm_word(pick_op(rng[6:4]), prev, dst, rng[11:8],
                                           rng[19:12]), 0);
                end else begin
                    send_instr(dp_reg_word(pick_op(rng[6:4]), prev, dst, rng[24:20],
                                           rng[26:25], prev), 0);
                end
                prev = dst;
            end
            check_reg(prev);
        end
        for (int n = 0; n < REG_COUNT; n++) begin
            check_reg(4'(n));
        end

        // shifted register operands, amount zero first
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                rng = xorshift(rng);
                src = rng[3:0];
                dst = rng[7:4];
                dst2 = rng[19:16];
                amt = (i == 0) ? 5'd0 : rng[12:8];
                load_reg(src);
                if (i[0]) begin
                    send_instr(dp_imm_word(OP_ORR, src, src, 4'h4, 8'h80), 0);
                end
                send_instr(dp_reg_word(OP_MOV, 4'h0, dst, amt, k[1:0], src), 0);
                send_instr(dp_reg_word(OP_ADD, dst, dst2, amt, k[1:0], src), 0);
                check_reg(dst);
                check_reg(dst2);
            end
        end

        // multiply and multiply-accumulate
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            src = rng[3:0];
            rs_i = rng[7:4];
            rn_i = rng[11:8];
            dst = rng[15:12];
            load_reg(src);
            load_reg(rs_i);
            load_reg(rn_i);
            send_instr(mul_word(i[0], dst, rn_i, rs_i, src), 0);
            check_reg(dst);
        end

        // error responses and ignored words
        write_word(8'h04, dp_imm_word(OP_MOV, 4'h0, 4'h0, 4'h0, 8'hFF), 4'hF, RESP_SLVERR, 0);
        write_word(INSTR_OFFSET, dp_imm_word(OP_MOV, 4'h0, 4'h1, 4'h0, 8'h5A), 4'h7,
                   RESP_SLVERR, 0);
        check_reg(4'h0);
        check_reg(4'h1);
        read_back(8'h40, 32'h0, RESP_SLVERR);
        read_back(8'hFC, 32'h0, RESP_SLVERR);
        send_instr(32'hE3E01000, 0);
        send_instr(32'hE5912000, 0);
        send_instr(32'hE0811312, 0);
        for (int n = 0; n < REG_COUNT; n++) begin
            check_reg(4'(n));
        end

        // response held back by bready
        send_instr(dp_imm_word(OP_MOV, 4'h0, 4'h7, 4'h2, 8'hC3), 6);
        write_word(8'h08, 32'h0, 4'hF, RESP_SLVERR, 4);
        check_reg(4'h7);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/core_pkg.sv
source/instr_intake.sv
source/register_file.sv
source/barrel_shift.sv
source/operand_decode.sv
source/execute_unit.sv
source/reg_readback.sv
source/dp_core_top.sv
verification/tb_dp_core.sv
